// ==== busDatapathPkg.sv ====
package busDatapathPkg;

    // Word and register file geometry
    localparam int dataWidth   = 32;
    localparam int regCount    = 16;
    localparam int regIdxWidth = 4;

    // RAM geometry, address taken from the low MAR bits
    localparam int memDepth  = 512;
    localparam int addrWidth = 9;

    // Immediate field width before sign extension
    localparam int immWidth = 19;

    // Bus source select, exactly one driver per cycle
    typedef enum logic [2:0] {
        srcNone    = 3'd0,
        srcPc      = 3'd1,
        srcMdr     = 3'd2,
        srcZLow    = 3'd3,
        srcReg     = 3'd4,
        srcConst   = 3'd5,
        srcInPort  = 3'd6
    } busSrc_e;

    // Instruction field that picks the general register
    typedef enum logic [1:0] {
        selRa = 2'd0,
        selRb = 2'd1,
        selRc = 2'd2
    } regSel_e;

    // ALU opcodes, same codes as the instruction opcode field
    typedef enum logic [4:0] {
        opAdd   = 5'd3,
        opSub   = 5'd4,
        opAnd   = 5'd5,
        opOr    = 5'd6,
        opShr   = 5'd7,
        opShl   = 5'd9,
        opNeg   = 5'd15,
        opNot   = 5'd16,
        opIncPc = 5'd31
    } aluOp_e;

    // One cycle of control from the sequencer
    typedef struct packed {
        busSrc_e busSrc;
        regSel_e regSel;
        logic    baOut;
        logic    regIn;
        logic    pcIn;
        logic    incPc;
        logic    marIn;
        logic    mdrIn;
        logic    memRead;
        logic    ramWrite;
        logic    irIn;
        logic    yIn;
        logic    zIn;
        aluOp_e  aluOp;
        logic    outPortIn;
    } ctrlWord_t;

    // Decoded instruction register
    typedef struct packed {
        logic [4:0]             opcode;
        logic [regIdxWidth-1:0] ra;
        logic [regIdxWidth-1:0] rb;
        logic [regIdxWidth-1:0] rc;
        logic [dataWidth-1:0]   constVal;
    } instrFields_t;

endpackage

// ==== fetchRegs.sv ====
`timescale 1ns/1ps

module fetchRegs import busDatapathPkg::*; (
    input  logic                 Clock,
    input  logic                 arstN,
    input  logic [dataWidth-1:0] bus,
    input  logic                 pcIn,
    input  logic                 incPc,
    input  logic                 irIn,
    output logic [dataWidth-1:0] pcValue,
    output instrFields_t         fields
);

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] ir;
    logic [dataWidth-1:0] pcPlusOne;

    // Dedicated incrementer, fetch never needs the ALU
    assign pcPlusOne = pc + dataWidth'(1);

    // Program counter
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (pcIn) begin
            // Increment wins over the bus value
            if (incPc) begin
                pc <= pcPlusOne;
            end else begin
                pc <= bus;
            end
        end
    end

    // Instruction register, loaded from the bus
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            ir <= '0;
        end else if (irIn) begin
            ir <= bus;
        end
    end

    assign pcValue = pc;

    // Field decode
    // Opcode 31:27, Ra 26:23, Rb 22:19, Rc 18:15
    always_comb begin
        fields.opcode = ir[31:27];
        fields.ra     = ir[26:23];
        fields.rb     = ir[22:19];
        fields.rc     = ir[18:15];
        // Immediate overlaps Rc, sign bit is bit 18
        fields.constVal = {{(dataWidth-immWidth){ir[immWidth-1]}}, ir[immWidth-1:0]};
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile import busDatapathPkg::*; (
    input  logic                 Clock,
    input  logic                 arstN,
    input  logic [dataWidth-1:0] bus,
    input  instrFields_t         fields,
    input  regSel_e              regSel,
    input  logic                 baOut,
    input  logic                 regIn,
    output logic [dataWidth-1:0] regValue
);

    // General registers R0..R15
    logic [dataWidth-1:0]   regs [regCount];

    // Register index after select
    logic [regIdxWidth-1:0] regIdx;

    // Decoded one-hot of the selected register
    logic [regCount-1:0]    regHot;

    // Base-address rule hits when R0 is picked
    logic                   baZero;

    // Select stage
    // One of Ra, Rb, Rc picked by the sequencer
    always_comb begin
        case (regSel)
            selRa:   regIdx = fields.ra;
            selRb:   regIdx = fields.rb;
            selRc:   regIdx = fields.rc;
            default: regIdx = fields.ra;
        endcase
    end

    // Encode stage
    // One write strobe per register, like the classic select-and-encode block
    always_comb begin
        regHot = '0;
        regHot[regIdx] = 1'b1;
    end

    // Register array write
    // Only the encoded register loads, and only with regIn
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regIn) begin
            for (int i = 0; i < regCount; i++) begin
                if (regHot[i]) begin
                    regs[i] <= bus;
                end
            end
        end
    end

    // R0 reads as zero for base-address use
    assign baZero = baOut && regHot[0];

    // Read path onto the bus mux
    always_comb begin
        if (baZero) begin
            regValue = '0;
        end else begin
            regValue = regs[regIdx];
        end
    end

endmodule

// ==== aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit import busDatapathPkg::*; (
    input  logic                 Clock,
    input  logic                 arstN,
    input  logic [dataWidth-1:0] bus,
    input  logic                 yIn,
    input  logic                 zIn,
    input  aluOp_e               aluOp,
    output logic [dataWidth-1:0] zLow
);

    // Operand register
    logic [dataWidth-1:0] y;

    // Result register, low word only
    logic [dataWidth-1:0] z;

    // Combinational result
    logic [dataWidth-1:0] aluResult;

    // Shift amount from the bus
    logic [4:0]           shiftAmt;

    assign shiftAmt = bus[4:0];

    // Y takes the first operand from the bus
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            y <= '0;
        end else if (yIn) begin
            y <= bus;
        end
    end

    // ALU
    // A is Y, B is the bus
    always_comb begin
        case (aluOp)
            // Wrap-around arithmetic
            opAdd:   aluResult = y + bus;
            opSub:   aluResult = y - bus;
            // Bitwise logic
            opAnd:   aluResult = y & bus;
            opOr:    aluResult = y | bus;
            // Logical shifts of Y
            opShr:   aluResult = y >> shiftAmt;
            opShl:   aluResult = y << shiftAmt;
            // Unary ops act on the bus
            opNeg:   aluResult = ~bus + dataWidth'(1);
            opNot:   aluResult = ~bus;
            // Bus value plus one, e.g. PC through the ALU
            opIncPc: aluResult = bus + dataWidth'(1);
            default: aluResult = '0;
        endcase
    end

    // Z captures the result, holds until reloaded
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            z <= '0;
        end else if (zIn) begin
            z <= aluResult;
        end
    end

    assign zLow = z;

endmodule

// ==== memInterface.sv ====
`timescale 1ns/1ps

module memInterface import busDatapathPkg::*; (
    input  logic                 Clock,
    input  logic                 arstN,
    input  logic [dataWidth-1:0] bus,
    input  logic                 marIn,
    input  logic                 mdrIn,
    input  logic                 memRead,
    input  logic                 ramWrite,
    output logic [dataWidth-1:0] mdrValue
);

    // Memory address register, only the RAM address bits kept
    logic [addrWidth-1:0] mar;

    // Memory data register
    logic [dataWidth-1:0] mdr;

    // MDR input after the RAM/bus mux
    logic [dataWidth-1:0] mdrD;

    // RAM word at the current address
    logic [dataWidth-1:0] ramRdData;

    // RAM array, no reset
    logic [dataWidth-1:0] ram [memDepth];

    // MAR load from the bus
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            mar <= '0;
        end else if (marIn) begin
            mar <= bus[addrWidth-1:0];
        end
    end

    // Read port, sampled by MDR at the edge
    assign ramRdData = ram[mar];

    // MDR input mux
    // RAM under memRead, otherwise the bus
    assign mdrD = memRead ? ramRdData : bus;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            mdr <= '0;
        end else if (mdrIn) begin
            mdr <= mdrD;
        end
    end

    // Write port
    // Data always comes from MDR
    always_ff @(posedge Clock) begin
        if (ramWrite) begin
            ram[mar] <= mdr;
        end
    end

    assign mdrValue = mdr;

endmodule

// ==== busDatapath.sv ====
`timescale 1ns/1ps

module busDatapath import busDatapathPkg::*; (
    input  logic                 Clock,
    input  logic                 arstN,
    input  ctrlWord_t            ctrl,
    input  logic [dataWidth-1:0] inPort,
    output logic [dataWidth-1:0] busValue,
    output logic [dataWidth-1:0] outPort
);

    // Shared bus
    logic [dataWidth-1:0] bus;

    // Source values returned to the mux
    logic [dataWidth-1:0] pcValue;
    logic [dataWidth-1:0] mdrValue;
    logic [dataWidth-1:0] zLow;
    logic [dataWidth-1:0] regValue;

    // Decoded instruction
    instrFields_t         fields;

    // PC and IR with field decode
    fetchRegs i_fetch (
        .Clock   (Clock),
        .arstN   (arstN),
        .bus     (bus),
        .pcIn    (ctrl.pcIn),
        .incPc   (ctrl.incPc),
        .irIn    (ctrl.irIn),
        .pcValue (pcValue),
        .fields  (fields)
    );

    // General registers steered by IR fields
    regFile i_regs (
        .Clock    (Clock),
        .arstN    (arstN),
        .bus      (bus),
        .fields   (fields),
        .regSel   (ctrl.regSel),
        .baOut    (ctrl.baOut),
        .regIn    (ctrl.regIn),
        .regValue (regValue)
    );

    aluUnit i_alu (
        .Clock (Clock),
        .arstN (arstN),
        .bus   (bus),
        .yIn   (ctrl.yIn),
        .zIn   (ctrl.zIn),
        .aluOp (ctrl.aluOp),
        .zLow  (zLow)
    );

    memInterface i_mem (
        .Clock    (Clock),
        .arstN    (arstN),
        .bus      (bus),
        .marIn    (ctrl.marIn),
        .mdrIn    (ctrl.mdrIn),
        .memRead  (ctrl.memRead),
        .ramWrite (ctrl.ramWrite),
        .mdrValue (mdrValue)
    );

    // Bus mux
    // Single select field, so never two drivers
    always_comb begin
        case (ctrl.busSrc)
            srcPc:     bus = pcValue;
            srcMdr:    bus = mdrValue;
            srcZLow:   bus = zLow;
            srcReg:    bus = regValue;
            srcConst:  bus = fields.constVal;
            srcInPort: bus = inPort;
            // srcNone parks the bus at zero
            default:   bus = '0;
        endcase
    end

    assign busValue = bus;

    // Output port register
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            outPort <= '0;
        end else if (ctrl.outPortIn) begin
            outPort <= bus;
        end
    end

endmodule

// ==== busDatapath_props.sv ====
`timescale 1ns/1ps

module busDatapath_props import busDatapathPkg::*; (
    input logic                 Clock,
    input logic                 arstN,
    input ctrlWord_t            ctrl,
    input logic [dataWidth-1:0] bus,
    input logic [dataWidth-1:0] mdrValue,
    input logic [dataWidth-1:0] ramRdData,
    input logic [dataWidth-1:0] outPort
);

    // Output port parked at zero while reset is low
    outPortReset: assert property (@(posedge Clock) !arstN |-> outPort == '0)
        else $error("outPort not zero during reset");

    // No source selected means a zero bus
    busIdle: assert property (@(posedge Clock) ctrl.busSrc == srcNone |-> bus == '0)
        else $error("bus not zero with no source selected");

    // MDR takes the RAM word only under memRead
    mdrFromRam: assert property (@(posedge Clock) disable iff (!arstN)
        ctrl.mdrIn && ctrl.memRead |=> mdrValue == $past(ramRdData))
        else $error("MDR did not load the RAM word");

    // Otherwise it takes the bus
    mdrFromBus: assert property (@(posedge Clock) disable iff (!arstN)
        ctrl.mdrIn && !ctrl.memRead |=> mdrValue == $past(bus))
        else $error("MDR did not load the bus value");

endmodule

// ==== busDatapathTb.sv ====
`timescale 1ns/1ps

module busDatapathTb import busDatapathPkg::*; ();

    localparam int halfPeriod   = 50;
    localparam int resetTimeout = 20;
    localparam int runTimeout   = 2000;

    // One table row holds control word, port input and expected bus
    typedef struct packed {
        ctrlWord_t            ctrl;
        logic [dataWidth-1:0] inPort;
        logic [dataWidth-1:0] expBus;
        logic                 check;
        logic                 aluCheck;
    } tableRow_t;

    logic                 Clock;
    logic                 arstN;
    ctrlWord_t            ctrl;
    logic [dataWidth-1:0] inPort;
    logic [dataWidth-1:0] busValue;
    logic [dataWidth-1:0] outPort;

    tableRow_t            rows[$];
    logic [dataWidth-1:0] expOut;
    integer               seed;
    int                   errorCount;
    int                   checkCount;
    int                   waitCount;

    busDatapath i_dut (
        .Clock    (Clock),
        .arstN    (arstN),
        .ctrl     (ctrl),
        .inPort   (inPort),
        .busValue (busValue),
        .outPort  (outPort)
    );

    // Property checker sits inside every busDatapath instance
    bind busDatapath busDatapath_props i_props (
        .Clock     (Clock),
        .arstN     (arstN),
        .ctrl      (ctrl),
        .bus       (bus),
        .mdrValue  (mdrValue),
        .ramRdData (i_mem.ramRdData),
        .outPort   (outPort)
    );

    // 100 ns clock
    always #halfPeriod Clock = ~Clock;

    task automatic compareWord(input logic [dataWidth-1:0] got, input logic [dataWidth-1:0] exp,
                               input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // ALU result check naming the opcode that produced Z
    task automatic compareCtrl(input aluOp_e op, input logic [dataWidth-1:0] got,
                               input logic [dataWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error at %0d ns: Z after %s is %h, expected %h", $time, op.name(), got, exp);
        end
    endtask

    // Arithmetic rules with A from Y and B from the bus
    function automatic logic [dataWidth-1:0] expectedAlu(aluOp_e op, logic [dataWidth-1:0] a,
                                                         logic [dataWidth-1:0] b);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opShr:   return a >> b[4:0];
            opShl:   return a << b[4:0];
            opNeg:   return -b;
            opNot:   return ~b;
            default: return b + 1;
        endcase
    endfunction

    // Idle control word with one bus source
    function automatic ctrlWord_t srcCtrl(busSrc_e src);
        ctrlWord_t c;
        c = '0;
        c.busSrc = src;
        c.aluOp = opAdd;
        return c;
    endfunction

    task automatic addRow(input ctrlWord_t c, input logic [dataWidth-1:0] inP,
                          input logic [dataWidth-1:0] expV, input logic chk, input logic aluChk);
        tableRow_t r;
        r.ctrl = c;
        r.inPort = inP;
        r.expBus = expV;
        r.check = chk;
        r.aluCheck = aluChk;
        rows.push_back(r);
    endtask

    task automatic buildTable(output logic [dataWidth-1:0] portExp);
        ctrlWord_t            c;
        logic [dataWidth-1:0] prog [4];
        logic [dataWidth-1:0] addrs [4];
        logic [dataWidth-1:0] imms [2];
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] rbVal;
        logic [dataWidth-1:0] res;
        logic [dataWidth-1:0] pcModel;
        logic [dataWidth-1:0] r0Val;
        aluOp_e               ops [9];
        // Every source reads zero after reset
        addRow(srcCtrl(srcPc), 0, 0, 1'b1, 1'b0);
        addRow(srcCtrl(srcMdr), 0, 0, 1'b1, 1'b0);
        addRow(srcCtrl(srcZLow), 0, 0, 1'b1, 1'b0);
        addRow(srcCtrl(srcConst), 0, 0, 1'b1, 1'b0);
        c = srcCtrl(srcReg);
        addRow(c, 0, 0, 1'b1, 1'b0);
        c.regSel = selRb;
        addRow(c, 0, 0, 1'b1, 1'b0);
        c.regSel = selRc;
        addRow(c, 0, 0, 1'b1, 1'b0);
        // Nonzero R0 through the all-zero IR fields
        r0Val = $random(seed) | 32'h1;
        c = srcCtrl(srcInPort);
        c.regSel = selRa;
        c.regIn = 1'b1;
        addRow(c, r0Val, r0Val, 1'b1, 1'b0);
        addRow(srcCtrl(srcReg), 0, r0Val, 1'b1, 1'b0);
        // Two OR-immediate instructions building R3 from R0 and R4 from R3
        for (int k = 0; k < 2; k++) begin
            a = $random(seed);
            imms[k] = {{(dataWidth-19){a[18]}}, a[18:0]};
            prog[k] = {opOr, 4'(k + 3), 4'(k * 3), a[18:0]};
        end
        prog[2] = $random(seed);
        prog[3] = $random(seed);
        addrs = '{32'd0, 32'd1, 32'd200, 32'd511};
        // Program load from the input port
        for (int i = 0; i < 4; i++) begin
            c = srcCtrl(srcInPort);
            c.marIn = 1'b1;
            addRow(c, addrs[i], addrs[i], 1'b1, 1'b0);
            c = srcCtrl(srcInPort);
            c.mdrIn = 1'b1;
            addRow(c, prog[i], prog[i], 1'b1, 1'b0);
            c = srcCtrl(srcNone);
            c.ramWrite = 1'b1;
            addRow(c, 0, 0, 1'b1, 1'b0);
        end
        // Read back through MAR and MDR
        for (int i = 0; i < 4; i++) begin
            c = srcCtrl(srcInPort);
            c.marIn = 1'b1;
            addRow(c, addrs[i], addrs[i], 1'b1, 1'b0);
            c = srcCtrl(srcNone);
            c.mdrIn = 1'b1;
            c.memRead = 1'b1;
            addRow(c, 0, 0, 1'b1, 1'b0);
            addRow(srcCtrl(srcMdr), 0, prog[i], 1'b1, 1'b0);
        end
        // Fetch then execute for both instructions
        pcModel = '0;
        rbVal = '0;
        for (int k = 0; k < 2; k++) begin
            c = srcCtrl(srcPc);
            c.marIn = 1'b1;
            addRow(c, 0, pcModel, 1'b1, 1'b0);
            c = srcCtrl(srcNone);
            c.mdrIn = 1'b1;
            c.memRead = 1'b1;
            addRow(c, 0, 0, 1'b1, 1'b0);
            c = srcCtrl(srcNone);
            c.pcIn = 1'b1;
            c.incPc = 1'b1;
            addRow(c, 0, 0, 1'b1, 1'b0);
            pcModel = pcModel + 1;
            c = srcCtrl(srcMdr);
            c.irIn = 1'b1;
            addRow(c, 0, prog[k], 1'b1, 1'b0);
            // Rb into Y with R0 forced to zero by baOut
            c = srcCtrl(srcReg);
            c.regSel = selRb;
            c.baOut = 1'b1;
            c.yIn = 1'b1;
            addRow(c, 0, rbVal, 1'b1, 1'b0);
            c = srcCtrl(srcConst);
            c.aluOp = opOr;
            c.zIn = 1'b1;
            addRow(c, 0, imms[k], 1'b1, 1'b0);
            res = rbVal | imms[k];
            c = srcCtrl(srcZLow);
            c.regSel = selRa;
            c.regIn = 1'b1;
            c.aluOp = opOr;
            addRow(c, 0, res, 1'b1, 1'b1);
            c = srcCtrl(srcReg);
            c.regSel = selRa;
            addRow(c, 0, res, 1'b1, 1'b0);
            // R3 becomes the Rb of the second instruction
            rbVal = res;
        end
        // Every opcode on random operands with the PC feeding the increment
        ops = '{opAdd, opSub, opAnd, opOr, opShr, opShl, opNeg, opNot, opIncPc};
        for (int i = 0; i < 9; i++) begin
            a = $random(seed);
            b = $random(seed);
            c = srcCtrl(srcInPort);
            c.yIn = 1'b1;
            addRow(c, a, a, 1'b1, 1'b0);
            if (ops[i] == opIncPc) begin
                b = pcModel;
                c = srcCtrl(srcPc);
            end else begin
                c = srcCtrl(srcInPort);
            end
            c.aluOp = ops[i];
            c.zIn = 1'b1;
            addRow(c, b, b, 1'b1, 1'b0);
            c = srcCtrl(srcZLow);
            c.aluOp = ops[i];
            addRow(c, 0, expectedAlu(ops[i], a, b), 1'b1, 1'b1);
        end
        // R4 to the output port followed by unrelated bus traffic
        c = srcCtrl(srcReg);
        c.regSel = selRa;
        c.outPortIn = 1'b1;
        addRow(c, 0, res, 1'b1, 1'b0);
        a = $random(seed);
        c = srcCtrl(srcInPort);
        c.yIn = 1'b1;
        addRow(c, a, a, 1'b1, 1'b0);
        addRow(srcCtrl(srcPc), 0, pcModel, 1'b1, 1'b0);
        portExp = res;
    endtask

    // Reset held low for 5 cycles
    initial begin
        arstN = 1'b1;
        #5;
        arstN = 1'b0;
        repeat (5) @(posedge Clock);
        #1;
        arstN = 1'b1;
    end

    // Guard against a stuck run
    initial begin
        #(runTimeout * 2 * halfPeriod);
        $display("Simulation did not finish within %0d cycles", runTimeout);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed = 32'h1d4e6951;
        errorCount = 0;
        checkCount = 0;
        Clock = 1'b0;
        ctrl = srcCtrl(srcNone);
        inPort = '0;
        buildTable(expOut);
        // outPort must read zero all through reset
        waitCount = 0;
        do begin
            @(negedge Clock);
            compareWord(outPort, '0, "outPort in reset");
            waitCount++;
        end while (arstN !== 1'b1 && waitCount < resetTimeout);
        if (arstN !== 1'b1) begin
            $display("Reset was not released within %0d cycles", resetTimeout);
            $display("Test failed");
            $finish;
        end
        // One row per cycle with the bus sampled just before the next edge
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge Clock);
            #1;
            ctrl = rows[i].ctrl;
            inPort = rows[i].inPort;
            #97;
            if (rows[i].check && rows[i].aluCheck) begin
                compareCtrl(rows[i].ctrl.aluOp, busValue, rows[i].expBus);
            end else if (rows[i].check) begin
                compareWord(busValue, rows[i].expBus, $sformatf("bus in row %0d", i));
            end
        end
        @(posedge Clock);
        #1;
        ctrl = srcCtrl(srcNone);
        inPort = '0;
        @(negedge Clock);
        compareWord(outPort, expOut, "outPort after bus traffic");
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== busDatapath.f ====
busDatapathPkg.sv
fetchRegs.sv
regFile.sv
aluUnit.sv
memInterface.sv
busDatapath.sv
busDatapath_props.sv
busDatapathTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the busDatapath testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
logFile=sim.log

verilator --binary --timing --assert --top-module busDatapathTb \
    -f busDatapath.f -o busDatapathSim

./obj_dir/busDatapathSim 2>&1 | tee "$logFile"

if grep -q "Test failed" "$logFile"; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation passed"
